//--- hdl/i2c_pkg.sv
package i2c_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int I2C_ADDR_W = 7;
    localparam int I2C_BYTE_W = 8;

    // Bus operations run by the engine
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_STOP  = 2'd3
    } i2c_op_e;

    // ==================================================
    // Host side
    // ==================================================
    typedef struct packed {
        logic [I2C_ADDR_W-1:0] slave_addr;
        logic                  rw;          // 1 = read
        logic [I2C_BYTE_W-1:0] tx_data;
    } i2c_cmd_t;

    typedef struct packed {
        logic tx_ready;
        logic busy;
        logic tx_done;     // One cycle pulse
        logic rx_done;     // One cycle pulse
        logic ack_error;   // One cycle pulse
    } i2c_status_t;

    // ==================================================
    // Controller to engine
    // ==================================================
    typedef struct packed {
        i2c_op_e               op;
        logic [I2C_BYTE_W-1:0] data;
    } bus_op_t;

    typedef struct packed {
        logic                  ack;         // Slave pulled SDA low in ACK slot
        logic [I2C_BYTE_W-1:0] rx_byte;
    } bus_result_t;

endpackage

//--- hdl/i2c_bus_engine.sv
`timescale 1ns/100ps

module i2c_bus_engine #(
    parameter int QUARTER_CYCLES = 250
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                op_valid,
    input  i2c_pkg::bus_op_t    op_in,
    input  logic                sda_in,
    output logic                op_done,
    output i2c_pkg::bus_result_t result,
    output logic                scl,
    output logic                sda_low
);

    import i2c_pkg::*;

    // Quarter counter sizing, QUARTER_CYCLES must be 2 or more
    localparam int CNT_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam logic [CNT_W-1:0] Q_LAST = CNT_W'(QUARTER_CYCLES - 1);
    localparam logic [CNT_W-1:0] Q_MID  = CNT_W'(QUARTER_CYCLES / 2);
    localparam logic [CNT_W-1:0] Q_DONE = CNT_W'(QUARTER_CYCLES - 2);

    // ==================================================
    // Sequencer state
    // ==================================================
    logic                  active;
    i2c_op_e               op_q;
    logic [CNT_W-1:0]      q_cnt;      // Clocks within a quarter
    logic [1:0]            q_idx;      // Quarter within the bit
    logic [3:0]            bit_cnt;    // 0..8, bit 8 is the ACK slot

    logic [I2C_BYTE_W-1:0] shift_q;    // Tx byte out, rx byte in
    logic                  sda_bit;    // Last sampled SDA level

    logic                  is_byte;
    logic [3:0]            last_bit;
    logic                  last_quarter;
    logic                  sample_tick;
    logic                  bit_end;

    // SCL level for a given quarter of an operation
    function automatic logic scl_level(i2c_op_e op, logic [1:0] idx);
        case (op)
            OP_START: return idx != 2'd3;      // High, high, high, low
            OP_STOP:  return idx != 2'd0;      // Low, high, high, high
            default:  return idx[1] ^ idx[0];  // Low, high, high, low
        endcase
    endfunction

    assign is_byte      = (op_q == OP_WRITE) || (op_q == OP_READ);
    assign last_bit     = is_byte ? 4'd8 : 4'd0;
    assign last_quarter = (q_idx == 2'd3) && (bit_cnt == last_bit);
    assign sample_tick  = active && (q_idx == 2'd1) && (q_cnt == Q_MID);
    assign bit_end      = active && (q_idx == 2'd3) && (q_cnt == Q_LAST);

    // ==================================================
    // Timer and bit sequencer
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active  <= 1'b0;
            op_q    <= OP_START;
            q_cnt   <= '0;
            q_idx   <= 2'd0;
            bit_cnt <= 4'd0;
            scl     <= 1'b1;   // Bus idle
            op_done <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (!active) begin
                if (op_valid) begin
                    active  <= 1'b1;
                    op_q    <= op_in.op;
                    q_cnt   <= '0;
                    q_idx   <= 2'd0;
                    bit_cnt <= 4'd0;
                    scl     <= scl_level(op_in.op, 2'd0);
                end
            end else begin
                // Registered, so raised one clock before the final edge
                if (last_quarter && (q_cnt == Q_DONE)) begin
                    op_done <= 1'b1;
                end

                if (q_cnt == Q_LAST) begin
                    q_cnt <= '0;
                    if (last_quarter) begin
                        active <= 1'b0;     // SCL keeps its last level
                    end else begin
                        q_idx <= q_idx + 2'd1;
                        scl   <= scl_level(op_q, q_idx + 2'd1);
                        if (q_idx == 2'd3) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end else begin
                    q_cnt <= q_cnt + 1'b1;
                end
            end
        end
    end

    // ==================================================
    // Data path
    // ==================================================
    always_ff @(posedge clk) begin
        if (!active && op_valid) begin
            shift_q <= op_in.data;
        end else if (bit_end && is_byte && (bit_cnt < 4'd8)) begin
            shift_q <= {shift_q[I2C_BYTE_W-2:0], sda_bit};  // MSB first
        end

        if (sample_tick) begin
            sda_bit <= sda_in;
        end

        // ACK slot sample is already in sda_bit here
        if (active && last_quarter && (q_cnt == Q_DONE)) begin
            result.ack     <= ~sda_bit;
            result.rx_byte <= shift_q;
        end
    end

    // Open-drain drive, only ever pulls low
    always_comb begin
        sda_low = 1'b0;
        if (active) begin
            case (op_q)
                OP_START: sda_low = q_idx[1];                        // Falls in quarter 2
                OP_STOP:  sda_low = ~q_idx[1];                       // Rises in quarter 2
                OP_WRITE: sda_low = (bit_cnt < 4'd8) && !shift_q[I2C_BYTE_W-1];
                default:  sda_low = 1'b0;   // Read data and NACK slot released
            endcase
        end
    end

endmodule

//--- hdl/i2c_master_ctrl.sv
`timescale 1ns/100ps

module i2c_master_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  i2c_pkg::i2c_cmd_t               cmd,
    input  logic                            en,
    input  logic                            start,
    input  logic                            stop,
    input  logic                            op_done,
    input  i2c_pkg::bus_result_t            result,
    output i2c_pkg::i2c_status_t            status,
    output logic [i2c_pkg::I2C_BYTE_W-1:0]  rx_data,
    output logic                            op_valid,
    output i2c_pkg::bus_op_t                op_out
);

    import i2c_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        HOLD,
        DO_START,
        DO_ADDR,
        DO_DATA,
        DO_STOP
    } state_e;

    // ==================================================
    // Registers
    // ==================================================
    state_e                state;
    logic                  issued;      // Op of current state sent to engine
    logic                  tx_done_q;
    logic                  rx_done_q;
    logic                  ack_err_q;

    logic [I2C_BYTE_W-1:0] addr_byte;   // {slave_addr, rw}
    logic [I2C_BYTE_W-1:0] tx_byte;

    logic                  ready;
    logic                  cmd_load;
    logic                  data_load;
    logic                  rx_load;
    logic                  rd_mode;

    assign ready   = (state == IDLE) || (state == HOLD);
    assign rd_mode = addr_byte[0];

    // New address on a fresh transaction or repeated START
    assign cmd_load  = ((state == IDLE) && en) || ((state == HOLD) && start);
    assign data_load = (state == HOLD) && en && !start && !stop;
    assign rx_load   = (state == DO_DATA) && op_done && rd_mode;

    // One op per DO_ state, sent on the first cycle there
    assign op_valid = !ready && !issued;

    always_comb begin
        op_out.data = tx_byte;
        case (state)
            DO_START: op_out.op = OP_START;
            DO_ADDR: begin
                op_out.op   = OP_WRITE;
                op_out.data = addr_byte;
            end
            DO_DATA:  op_out.op = rd_mode ? OP_READ : OP_WRITE;
            default:  op_out.op = OP_STOP;
        endcase
    end

    // ==================================================
    // Transaction FSM
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            issued    <= 1'b0;
            tx_done_q <= 1'b0;
            rx_done_q <= 1'b0;
            ack_err_q <= 1'b0;
        end else begin
            tx_done_q <= 1'b0;
            rx_done_q <= 1'b0;
            ack_err_q <= 1'b0;

            if (op_valid) begin
                issued <= 1'b1;
            end else if (op_done) begin
                issued <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (en) begin
                        state <= DO_START;
                    end
                end

                HOLD: begin
                    if (start) begin
                        state <= DO_START;       // Repeated START
                    end else if (stop) begin
                        state <= DO_STOP;
                    end else if (en) begin
                        state <= DO_DATA;        // Next byte, same direction
                    end
                end

                DO_START: begin
                    if (op_done) begin
                        state <= DO_ADDR;
                    end
                end

                DO_ADDR: begin
                    if (op_done) begin
                        if (result.ack) begin
                            state <= DO_DATA;
                        end else begin
                            ack_err_q <= 1'b1;   // No slave at this address
                            state     <= DO_STOP;
                        end
                    end
                end

                DO_DATA: begin
                    if (op_done) begin
                        if (rd_mode) begin
                            rx_done_q <= 1'b1;
                            state     <= HOLD;
                        end else begin
                            tx_done_q <= 1'b1;
                            if (result.ack) begin
                                state <= HOLD;
                            end else begin
                                ack_err_q <= 1'b1;
                                state     <= DO_STOP;
                            end
                        end
                    end
                end

                DO_STOP: begin
                    if (op_done) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // Command and receive capture
    always_ff @(posedge clk) begin
        if (cmd_load) begin
            addr_byte <= {cmd.slave_addr, cmd.rw};
            tx_byte   <= cmd.tx_data;
        end else if (data_load) begin
            tx_byte <= cmd.tx_data;   // Unused on a read
        end

        if (rx_load) begin
            rx_data <= result.rx_byte;
        end
    end

    always_comb begin
        status.tx_ready  = ready;
        status.busy      = !ready;
        status.tx_done   = tx_done_q;
        status.rx_done   = rx_done_q;
        status.ack_error = ack_err_q;
    end

endmodule

//--- hdl/i2c_master_top.sv
`timescale 1ns/100ps

module i2c_master_top #(
    parameter int QUARTER_CYCLES = 250
) (
    input  logic                            clk,
    input  logic                            reset,
    input  i2c_pkg::i2c_cmd_t               cmd,
    input  logic                            en,
    input  logic                            start,
    input  logic                            stop,
    output i2c_pkg::i2c_status_t            status,
    output logic [i2c_pkg::I2C_BYTE_W-1:0]  rx_data,
    output logic                            scl,
    inout  logic                            sda
);

    import i2c_pkg::*;

    // ==================================================
    // Controller to engine
    // ==================================================
    bus_op_t     bus_op;
    bus_result_t bus_result;
    logic        op_valid;
    logic        op_done;
    logic        sda_low;

    i2c_master_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .en       (en),
        .start    (start),
        .stop     (stop),
        .op_done  (op_done),
        .result   (bus_result),
        .status   (status),
        .rx_data  (rx_data),
        .op_valid (op_valid),
        .op_out   (bus_op)
    );

    i2c_bus_engine #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) u_engine (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .op_in    (bus_op),
        .sda_in   (sda),
        .op_done  (op_done),
        .result   (bus_result),
        .scl      (scl),
        .sda_low  (sda_low)
    );

    // Open-drain pad, external pullup gives the high level
    assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

//--- dv/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  logic       scl,
    inout  wire        sda,
    input  logic [7:0] read_byte,
    output int         start_count,
    output int         stop_count,
    output int         nack_count,
    output int         wr_count,
    output logic [7:0] last_wr,
    output logic [6:0] last_addr,
    output logic       last_rw
);

    logic       drive_low;
    logic       sda_prev;
    logic       active;
    logic       in_addr;     // First byte after START
    logic       addressed;
    logic       reading;
    logic       skip_fall;   // SCL fall that closes the START
    logic       master_ack;
    logic [3:0] bit_idx;     // 0..7 data, 8 is the ACK slot
    logic [7:0] shift_in;
    logic [7:0] tx_shift;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        start_count = 0;
        stop_count  = 0;
        nack_count  = 0;
        wr_count    = 0;
        drive_low   = 1'b0;
        active      = 1'b0;
        skip_fall   = 1'b0;
        sda_prev    = 1'b1;
    end

    // ==================================================
    // START and STOP detection
    // ==================================================
    always @(sda) begin
        if (scl === 1'b1 && sda_prev === 1'b1 && sda === 1'b0) begin
            start_count = start_count + 1;
            active      = 1'b1;
            in_addr     = 1'b1;
            addressed   = 1'b0;
            reading     = 1'b0;
            skip_fall   = 1'b1;
            bit_idx     = 4'd0;
            drive_low   = 1'b0;
        end else if (scl === 1'b1 && sda_prev === 1'b0 && sda === 1'b1) begin
            stop_count = stop_count + 1;
            active     = 1'b0;
            drive_low  = 1'b0;
        end
        sda_prev = sda;
    end

    // Sample on SCL rise
    always @(posedge scl) begin
        if (active && !skip_fall) begin
            if (bit_idx < 4'd8) begin
                shift_in = {shift_in[6:0], sda};
            end else if (reading && !in_addr) begin
                master_ack = (sda === 1'b0);
                if (!master_ack) begin
                    nack_count = nack_count + 1;
                end
            end
        end
    end

    // ==================================================
    // Bit sequencing on SCL fall
    // ==================================================
    always @(negedge scl) begin
        if (active && skip_fall) begin
            skip_fall = 1'b0;
        end else if (active && bit_idx == 4'd7) begin
            bit_idx = 4'd8;
            if (in_addr) begin
                last_addr = shift_in[7:1];
                last_rw   = shift_in[0];
                addressed = (shift_in[7:1] == ADDR);
                reading   = shift_in[0];
                drive_low = addressed;             // Address ACK
            end else if (!reading) begin
                last_wr   = shift_in;
                wr_count  = wr_count + 1;
                drive_low = 1'b1;                  // Data ACK
            end else begin
                drive_low = 1'b0;                  // Master owns this slot
            end
        end else if (active && bit_idx == 4'd8) begin
            bit_idx   = 4'd0;
            drive_low = 1'b0;
            if (!addressed) begin
                active = 1'b0;                     // Not for us, wait for START
            end else if (reading && (in_addr || master_ack)) begin
                tx_shift  = read_byte;
                drive_low = !read_byte[7];
            end else if (reading) begin
                active = 1'b0;                     // NACK ends the read
            end
            in_addr = 1'b0;
        end else if (active) begin
            bit_idx = bit_idx + 4'd1;
            if (reading && !in_addr) begin
                drive_low = !tx_shift[4'd7 - bit_idx];
            end
        end
    end

endmodule

//--- dv/i2c_master_props.sv
`timescale 1ns/100ps

module i2c_master_props (
    input logic                 clk,
    input logic                 reset,
    input i2c_pkg::i2c_status_t status,
    input i2c_pkg::bus_op_t     bus_op,
    input logic                 scl,
    input logic                 sda
);

    import i2c_pkg::*;

    logic start_or_stop;

    // Op field reads OP_STOP in idle and hold too, so qualify with busy
    assign start_or_stop = status.busy &&
                           ((bus_op.op == OP_START) || (bus_op.op == OP_STOP));

    a_ready_busy: assert property (@(posedge clk) disable iff (reset)
        status.tx_ready != status.busy)
        else $error("tx_ready and busy are not complements");

    a_tx_done_pulse: assert property (@(posedge clk) disable iff (reset)
        status.tx_done |=> !status.tx_done)
        else $error("tx_done held longer than one cycle");

    a_rx_done_pulse: assert property (@(posedge clk) disable iff (reset)
        status.rx_done |=> !status.rx_done)
        else $error("rx_done held longer than one cycle");

    a_ack_error_pulse: assert property (@(posedge clk) disable iff (reset)
        status.ack_error |=> !status.ack_error)
        else $error("ack_error held longer than one cycle");

    // Data may only move while SCL is low
    a_sda_stable: assert property (@(posedge clk) disable iff (reset)
        (scl && $past(scl) && (sda !== $past(sda))) |-> start_or_stop)
        else $error("SDA changed while SCL high outside START or STOP");

endmodule

bind i2c_master_top i2c_master_props u_props (
    .clk    (clk),
    .reset  (reset),
    .status (status),
    .bus_op (bus_op),
    .scl    (scl),
    .sda    (sda)
);

//--- dv/tb_i2c_master.sv
`timescale 1ns/100ps

module tb_i2c_master;

    import i2c_pkg::*;

    localparam int         QUARTER_CYCLES = 4;
    localparam logic [6:0] SLAVE_ADDR     = 7'h50;
    localparam logic [6:0] BAD_ADDR       = 7'h23;
    // Quarters per test: write 116, read 80, NACK 44, repeated START 156
    localparam int         TEST_QUARTERS  = 116 + 80 + 44 + 156;
    localparam int         CYCLE_LIMIT    = 2 * TEST_QUARTERS * QUARTER_CYCLES;

    logic                  clk;
    logic                  reset;
    i2c_cmd_t              cmd;
    logic                  en;
    logic                  start;
    logic                  stop;
    i2c_status_t           status;
    logic [I2C_BYTE_W-1:0] rx_data;
    logic                  scl;
    wire                   sda;

    logic [7:0]            read_byte;
    logic [31:0]           rnd;
    integer                seed;
    int                    cycle_count;
    int                    tx_done_cnt;
    int                    rx_done_cnt;
    int                    ack_err_cnt;

    int                    start_count;
    int                    stop_count;
    int                    nack_count;
    int                    wr_count;
    logic [7:0]            last_wr;
    logic [6:0]            last_addr;
    logic                  last_rw;

    pullup (sda);

    i2c_master_top #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) u_i2c_master_top (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .en      (en),
        .start   (start),
        .stop    (stop),
        .status  (status),
        .rx_data (rx_data),
        .scl     (scl),
        .sda     (sda)
    );

    i2c_slave_model #(
        .ADDR (SLAVE_ADDR)
    ) u_slave (
        .scl         (scl),
        .sda         (sda),
        .read_byte   (read_byte),
        .start_count (start_count),
        .stop_count  (stop_count),
        .nack_count  (nack_count),
        .wr_count    (wr_count),
        .last_wr     (last_wr),
        .last_addr   (last_addr),
        .last_rw     (last_rw)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

    // Status pulse counters
    always @(negedge clk) begin
        if (!reset) begin
            if (status.tx_done) tx_done_cnt = tx_done_cnt + 1;
            if (status.rx_done) rx_done_cnt = rx_done_cnt + 1;
            if (status.ack_error) ack_err_cnt = ack_err_cnt + 1;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic issue_command(input logic [6:0] addr, input logic rw,
                                 input logic [7:0] data, input logic do_en,
                                 input logic do_start, input logic do_stop);
        @(negedge clk);
        cmd.slave_addr = addr;
        cmd.rw         = rw;
        cmd.tx_data    = data;
        en             = do_en;
        start          = do_start;
        stop           = do_stop;
        @(negedge clk);
        en    = 1'b0;
        start = 1'b0;
        stop  = 1'b0;
    endtask

    task automatic wait_for_done();
        while (!(status.tx_done || status.rx_done || status.ack_error)) @(negedge clk);
    endtask

    task automatic wait_until_idle();
        while (status.busy) @(negedge clk);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic check_reset_state();
        check_value("scl after reset", scl, 1);
        check_value("sda after reset", sda, 1);
        check_value("tx_ready after reset", status.tx_ready, 1);
        check_value("busy after reset", status.busy, 0);
        check_value("pulses after reset", tx_done_cnt + rx_done_cnt + ack_err_cnt, 0);
    endtask

    task automatic write_two_bytes();
        int stops_before;
        int wr_before;
        int err_before;
        stops_before = stop_count;
        wr_before    = wr_count;
        err_before   = ack_err_cnt;
        issue_command(SLAVE_ADDR, 1'b0, 8'h3c, 1'b1, 1'b0, 1'b0);
        wait_for_done();
        check_value("tx_done on first byte", status.tx_done, 1);
        check_value("ack_error on first byte", status.ack_error, 0);
        check_value("tx_ready in hold", status.tx_ready, 1);
        check_value("slave address", last_addr, SLAVE_ADDR);
        check_value("slave rw", last_rw, 0);
        check_value("slave write count", wr_count, wr_before + 1);
        check_value("first byte", last_wr, 8'h3c);
        issue_command(SLAVE_ADDR, 1'b0, 8'hc3, 1'b1, 1'b0, 1'b0);
        wait_for_done();
        check_value("tx_done on second byte", status.tx_done, 1);
        check_value("slave write count", wr_count, wr_before + 2);
        check_value("second byte", last_wr, 8'hc3);
        issue_command(SLAVE_ADDR, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
        wait_until_idle();
        check_value("stop count after write", stop_count, stops_before + 1);
        check_value("ack_error count after write", ack_err_cnt, err_before);
        check_value("scl idle after write", scl, 1);
        check_value("sda idle after write", sda, 1);
    endtask

    task automatic read_one_byte();
        int nacks_before;
        rnd          = $random(seed);
        read_byte    = rnd[7:0];
        nacks_before = nack_count;
        issue_command(SLAVE_ADDR, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
        wait_for_done();
        check_value("rx_done on read", status.rx_done, 1);
        check_value("rx_data on read", rx_data, read_byte);
        check_value("slave rw on read", last_rw, 1);
        check_value("master NACK seen", nack_count, nacks_before + 1);
        issue_command(SLAVE_ADDR, 1'b1, 8'h00, 1'b0, 1'b0, 1'b1);
        wait_until_idle();
    endtask

    task automatic nack_on_bad_address();
        int tx_before;
        int err_before;
        int stops_before;
        int wr_before;
        tx_before    = tx_done_cnt;
        err_before   = ack_err_cnt;
        stops_before = stop_count;
        wr_before    = wr_count;
        issue_command(BAD_ADDR, 1'b0, 8'h5a, 1'b1, 1'b0, 1'b0);
        wait_for_done();
        check_value("ack_error on bad address", status.ack_error, 1);
        check_value("tx_done on bad address", status.tx_done, 0);
        wait_until_idle();
        check_value("tx_done count", tx_done_cnt, tx_before);
        check_value("ack_error count", ack_err_cnt, err_before + 1);
        check_value("automatic stop", stop_count, stops_before + 1);
        check_value("no byte logged", wr_count, wr_before);
        check_value("address seen by slave", last_addr, BAD_ADDR);
    endtask

    task automatic repeated_start_read();
        int starts_before;
        int stops_before;
        rnd           = $random(seed);
        read_byte     = rnd[7:0];
        starts_before = start_count;
        stops_before  = stop_count;
        issue_command(SLAVE_ADDR, 1'b0, 8'h96, 1'b1, 1'b0, 1'b0);
        wait_for_done();
        check_value("tx_done before restart", status.tx_done, 1);
        check_value("byte before restart", last_wr, 8'h96);
        issue_command(SLAVE_ADDR, 1'b1, 8'h00, 1'b0, 1'b1, 1'b0);
        wait_for_done();
        check_value("rx_done after restart", status.rx_done, 1);
        issue_command(SLAVE_ADDR, 1'b1, 8'h00, 1'b0, 1'b0, 1'b1);
        wait_until_idle();
        check_value("rx_data after restart", rx_data, read_byte);
        check_value("start count", start_count, starts_before + 2);
        check_value("stop count", stop_count, stops_before + 1);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        cmd         = '0;
        en          = 1'b0;
        start       = 1'b0;
        stop        = 1'b0;
        read_byte   = 8'h00;
        seed        = 32'h6cb9_893d;
        cycle_count = 0;
        tx_done_cnt = 0;
        rx_done_cnt = 0;
        ack_err_cnt = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        write_two_bytes();
        read_one_byte();
        nack_on_bad_address();
        repeated_start_read();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- all.f
hdl/i2c_pkg.sv
hdl/i2c_bus_engine.sv
hdl/i2c_master_ctrl.sv
hdl/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/i2c_master_props.sv
dv/tb_i2c_master.sv
